//--- procStim.txt
// Each section: program length, program words, preset data count, data words
// (from address 0), expected store count, then address and data of each store
0029                 // Section 1, 41 program words
C135 C2F0 C020 8020  // LBI r1, r2, r0 then store r1 at 20
4165 D950 E154 E958  // ADDI, ADD, SUB, AND
F15C 8061 8082 80A3  // XOR, stores at 21 to 23
80C4 80E5 C100 8940  // Stores at 24 and 25, clear r1, load word 0
4241 8046 8961 4361  // Increment and store, load word 1 and increment
8067 8982 4481 8088  // Store, load word 2, increment, store
C503 45A1 DDB4 F598  // Dependent chain on r5, then r6 from r5 and r4
80C9 6102 80AA 80AB  // Store r6, taken BEQZ skips two stores
6905 80AC 2002 80CD  // BNEZ falls through, store, J over two stores
80CE 80CF 0000 80A0  // Store at 2F, HALT, younger store
80A0                 // Younger store
0003 1234 FFFF 00A0  // Preset data words
000C                 // 12 expected stores
0020 0035 0021 003A 0022 0025 0023 0045
0024 0030 0025 FFC5 0026 1235 0027 0000
0028 00A1 0029 00A9 002C 0008 002F 00A9
0007                 // Section 2, illegal opcode 00111 at word 3
C030 C17F 8020 3800  // LBI r0, LBI r1, store r1 at 30, illegal word
415F 8041 0000       // ADDI r2 = r1 - 1, store at 31, HALT
0000                 // No preset data
0002                 // 2 expected stores
0030 007F 0031 007E

//--- proc.f
procPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
proc.sv
tbClock.sv
tbProc.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = tbProc
FILELIST  = proc.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- tbProc.sv
`timescale 1ns/1ps
/* Testbench for proc. Programs, preset data and expected stores come from procStim.txt.
   ROM and data memory hold 256 words each and decode only the low address byte */
module tbProc;

   logic        clk, rstN, restart;
   logic [15:0] iAddr, iData, wbAdr, wbDatO, wbDatI;
   logic        iReq, wbCyc, wbStb, wbWe, wbAck, halted, err;

   logic [15:0] stim [128];             // Whole stimulus file
   logic [15:0] rom [256];
   logic [15:0] dataMem [256];
   logic [15:0] expAdr [$], expDat [$];
   logic [31:0] lfsr;
   int          ptr, storeCnt, errors, checks, tests, runCycles, cycleLimit;
   logic        romReq, ackNext, waiting, holding, errSeen;
   logic [15:0] romAddr;
   logic [1:0]  waitLeft;               // Wait cycles still owed before Ack
   logic [32:0] holdSig;                // We, Adr and DatO seen while waiting

   tbClock clock_i (.restart(restart), .clk(clk), .rstN(rstN));

   proc proc_i (
      .clk(clk), .rstN(rstN), .iAddr(iAddr), .iReq(iReq), .iData(iData),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
      .wbDatI(wbDatI), .wbAck(wbAck), .halted(halted), .err(err));

   // Galois LFSR, stepped once for every bit taken
   function automatic logic randomBit();
      logic outBit;
      outBit = lfsr[0];
      lfsr   = outBit ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      return outBit;
   endfunction

   task automatic reportFailure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic reportValue(input string name, input logic [15:0] expV, gotV);
      errors++;
      $display("ERR %s exp %h got %h", name, expV, gotV);
   endtask

   task automatic checkStore(input logic [15:0] adr, dat);
      checks++;
      if (storeCnt >= expAdr.size()) begin
         reportFailure($sformatf("Unexpected store of %h to address %h", dat, adr));
      end else begin
         if (adr !== expAdr[storeCnt])
            reportValue("wbAdr", expAdr[storeCnt], adr);
         if (dat !== expDat[storeCnt])
            reportValue("wbDatO", expDat[storeCnt], dat);
      end
      storeCnt++;
   endtask

   // Fills both memories, then reads one section of the stimulus
   task automatic loadSection();
      int n, memOps;
      memOps = 0;
      for (int a = 0; a < 256; a++) begin
         rom[a]     = {8'h00, a[7:0]};  // HALT opcode, address in the low bits
         dataMem[a] = {8'hD0, a[7:0]};
      end
      n = int'(stim[ptr]);
      ptr++;
      for (int i = 0; i < n; i++) begin
         rom[i] = stim[ptr + i];
         if (stim[ptr + i][15:12] == 4'b1000)
            memOps++;                   // LD or ST
      end
      ptr += n;
      cycleLimit = (n + 4 * memOps) * 20;
      n = int'(stim[ptr]);
      ptr++;
      for (int i = 0; i < n; i++)
         dataMem[i] = stim[ptr + i];    // Preset words from address 0
      ptr += n;
      n = int'(stim[ptr]);
      ptr++;
      expAdr.delete();
      expDat.delete();
      for (int i = 0; i < n; i++) begin
         expAdr.push_back(stim[ptr + 2 * i]);
         expDat.push_back(stim[ptr + 2 * i + 1]);
      end
      ptr += 2 * n;
      storeCnt  = 0;
      runCycles = 0;
   endtask

   task automatic runSection(input string name, input logic expErr);
      loadSection();
      wait (rstN === 1'b1);
      checks++;
      if ({iReq, wbCyc, halted, err} !== 4'b1000)
         reportValue("{iReq,wbCyc,halted,err}", 16'h8, {12'h0, iReq, wbCyc, halted, err});
      while (halted !== 1'b1)
         @(posedge clk);
      repeat (8) @(negedge clk);        // Window for a stray bus cycle after HALT
      checks += 3;
      if (storeCnt != expAdr.size())
         reportFailure($sformatf("%0d stores seen, %0d expected", storeCnt, expAdr.size()));
      if (halted !== 1'b1)
         reportValue("halted", 16'h1, {15'h0, halted});
      if (err !== expErr)
         reportValue("err", {15'h0, expErr}, {15'h0, err});
      tests++;
      $display("%s done: %0d stores, %0d errors so far", name, storeCnt, errors);
   endtask

   // ROM and Wishbone slave: sample at the rising edge, drive at the falling edge
   always begin : busModels
      @(posedge clk);
      romReq  = iReq;
      romAddr = iAddr;
      ackNext = 1'b0;
      if (!rstN) begin
         errSeen = 1'b0;
      end else begin
         if (errSeen && !err)
            reportFailure("err fell without a reset");
         errSeen = errSeen || err;
         if (halted && wbCyc)
            reportFailure("Bus cycle open after HALT");
         if (holding && !(wbCyc && wbStb))
            reportFailure("Cyc or Stb dropped before Ack");
         else if (holding && {wbWe, wbAdr, wbDatO} !== holdSig)
            reportFailure("Master signals changed while waiting for Ack");
      end
      holding = wbCyc && wbStb && !wbAck;
      holdSig = {wbWe, wbAdr, wbDatO};
      if (wbCyc && wbStb && wbAck) begin   // Transfer ends at this edge
         if (wbWe) begin
            dataMem[wbAdr[7:0]] = wbDatO;
            checkStore(wbAdr, wbDatO);
         end
      end else if (wbCyc && wbStb) begin   // Slave answers only Cyc with Stb
         if (!waiting) begin
            waitLeft[1] = randomBit();  // 0 to 3 wait cycles
            waitLeft[0] = randomBit();
            waiting     = 1'b1;
         end
         if (waitLeft == 2'd0) begin
            ackNext = 1'b1;
            waiting = 1'b0;
         end else begin
            waitLeft = waitLeft - 2'd1;
         end
      end
      @(negedge clk);
      if (romReq)
         iData = rom[romAddr[7:0]];     // Word requested one cycle earlier
      wbAck = ackNext;
      if (ackNext)
         wbDatI = dataMem[wbAdr[7:0]];
   end

   always @(posedge clk) begin : watchdog
      if (rstN && !halted) begin
         runCycles++;
         if (runCycles > cycleLimit) begin
            $display("Processor did not halt within %0d cycles", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
         end
      end
   end

   initial begin
      iData   = '0;
      wbDatI  = '0;
      wbAck   = 1'b0;
      restart = 1'b0;
      lfsr    = 32'h3997_6af4;
      ptr     = 0;
      errors  = 0;
      checks  = 0;
      tests   = 0;
      waiting = 1'b0;
      holding = 1'b0;
      errSeen = 1'b0;
      $readmemh("procStim.txt", stim);
      runSection("Program 1 (ALU, loads, interlock, branches, halt)", 1'b0);
      @(negedge clk);
      restart = 1'b1;                   // Second program starts from reset
      @(negedge clk);
      restart = 1'b0;
      runSection("Program 2 (illegal opcode)", 1'b1);
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps
/* Clock of 100 ns period. Reset is held low for 5 cycles at start and again
   after each rising edge of restart, and is released on a falling edge */
module tbClock (
   input  logic restart,
   output logic clk,
   output logic rstN
);

   initial clk = 1'b0;
   always #50 clk = ~clk;               // 100 ns period

   always begin
      rstN = 1'b0;                      // Asynchronous assert
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;                      // Release away from the active edge
      @(posedge restart);
   end

endmodule

//--- proc.sv
`timescale 1ns/1ps
/* Four-stage 16-bit core: fetch, decode, execute, memory with writeback.
   Instruction port is synchronous read, data port is a Wishbone master */
module proc (
   input  logic                       clk,
   input  logic                       rstN,
   output logic [procPkg::DATA_W-1:0] iAddr,
   output logic                       iReq,
   input  logic [procPkg::DATA_W-1:0] iData,
   output logic                       wbCyc,
   output logic                       wbStb,
   output logic                       wbWe,
   output logic [procPkg::DATA_W-1:0] wbAdr,
   output logic [procPkg::DATA_W-1:0] wbDatO,
   input  logic [procPkg::DATA_W-1:0] wbDatI,
   input  logic                       wbAck,
   output logic                       halted,
   output logic                       err
);

   logic [procPkg::DATA_W-1:0] fdInstr, fdPc;
   logic                       fdValid;
   logic                       deValid, deUseImm, deWrite;
   procPkg::opcodeT            deOp;
   procPkg::aluOpT             deAluOp;
   logic [procPkg::DATA_W-1:0] deA, deB, deImm, dePc;
   logic [procPkg::REG_AW-1:0] deDest;
   logic                       emValid, emLoad, emStore, emWrite, emHalt;
   logic [procPkg::DATA_W-1:0] emResult, emStoreData;
   logic [procPkg::REG_AW-1:0] emDest;
   logic                       redirect;
   logic [procPkg::DATA_W-1:0] redirectPc;
   logic                       wbRegWe;
   logic [procPkg::REG_AW-1:0] wbRegAddr;
   logic [procPkg::DATA_W-1:0] wbRegData;
   logic                       memBusy, hazard;

   fetchStage fetch_i (
      .clk(clk), .rstN(rstN), .stall(memBusy | hazard), .redirect(redirect),
      .halt(halted), .redirectPc(redirectPc), .iData(iData), .iAddr(iAddr), .iReq(iReq),
      .fdInstr(fdInstr), .fdPc(fdPc), .fdValid(fdValid));

   decodeStage decode_i (
      .clk(clk), .rstN(rstN), .fdInstr(fdInstr), .fdPc(fdPc), .fdValid(fdValid),
      .flush(redirect), .memBusy(memBusy),
      .exDest(deDest), .exWrite(deWrite), .exValid(deValid),           // Execute occupant
      .memDest(emDest), .memWrite(emWrite), .memValid(emValid),        // Memory occupant
      .wbRegWe(wbRegWe), .wbRegAddr(wbRegAddr), .wbRegData(wbRegData),
      .hazard(hazard), .err(err), .deValid(deValid), .deOp(deOp), .deAluOp(deAluOp),
      .deA(deA), .deB(deB), .deImm(deImm), .deUseImm(deUseImm), .dePc(dePc),
      .deDest(deDest), .deWrite(deWrite));

   executeStage execute_i (
      .clk(clk), .rstN(rstN), .memBusy(memBusy), .deValid(deValid), .deOp(deOp),
      .deAluOp(deAluOp), .deA(deA), .deB(deB), .deImm(deImm), .deUseImm(deUseImm),
      .dePc(dePc), .deDest(deDest), .deWrite(deWrite),
      .redirect(redirect), .redirectPc(redirectPc), .emValid(emValid), .emResult(emResult),
      .emStoreData(emStoreData), .emLoad(emLoad), .emStore(emStore), .emDest(emDest),
      .emWrite(emWrite), .emHalt(emHalt));

   memStage mem_i (
      .clk(clk), .rstN(rstN), .emValid(emValid), .emResult(emResult),
      .emStoreData(emStoreData), .emLoad(emLoad), .emStore(emStore), .emDest(emDest),
      .emWrite(emWrite), .emHalt(emHalt), .wbDatI(wbDatI), .wbAck(wbAck),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
      .memBusy(memBusy), .halted(halted),
      .wbRegWe(wbRegWe), .wbRegAddr(wbRegAddr), .wbRegData(wbRegData));

endmodule

//--- memStage.sv
`timescale 1ns/1ps
/* Wishbone classic master with word addresses, plus writeback and halt.
   Cyc drops for at least one cycle between two bus cycles */
module memStage (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic                       emValid,
   input  logic [procPkg::DATA_W-1:0] emResult,
   input  logic [procPkg::DATA_W-1:0] emStoreData,
   input  logic                       emLoad,
   input  logic                       emStore,
   input  logic [procPkg::REG_AW-1:0] emDest,
   input  logic                       emWrite,
   input  logic                       emHalt,
   input  logic [procPkg::DATA_W-1:0] wbDatI,
   input  logic                       wbAck,
   output logic                       wbCyc,
   output logic                       wbStb,
   output logic                       wbWe,
   output logic [procPkg::DATA_W-1:0] wbAdr,
   output logic [procPkg::DATA_W-1:0] wbDatO,
   output logic                       memBusy,
   output logic                       halted,
   output logic                       wbRegWe,
   output logic [procPkg::REG_AW-1:0] wbRegAddr,
   output logic [procPkg::DATA_W-1:0] wbRegData
);

   typedef enum logic {IDLE, WAIT} busStateT;

   busStateT busState;
   logic     memReq;                      // Load or store waiting in this stage

   assign memReq  = emValid && (emLoad || emStore) && !halted;
   assign memBusy = memReq && !(busState == WAIT && wbAck);  // Frees on Ack

   assign wbCyc  = (busState == WAIT);
   assign wbWe   = emStore;
   assign wbAdr  = emResult;              // Stage register holds while busy
   assign wbDatO = emStoreData;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         busState <= IDLE;
         wbStb    <= 1'b0;
         halted   <= 1'b0;
      end else begin
         case (busState)
            IDLE: if (memReq) begin
               busState <= WAIT;
               wbStb    <= 1'b1;
            end
            WAIT: if (wbAck) begin
               busState <= IDLE;
               wbStb    <= 1'b0;
            end
            default: busState <= IDLE;
         endcase
         if (emValid && emHalt)
            halted <= 1'b1;               // Younger ops are ignored from now on
      end
   end

   assign wbRegWe   = emValid && emWrite && !halted && !memBusy;
   assign wbRegAddr = emDest;
   assign wbRegData = emLoad ? wbDatI : emResult;  // Load data is taken with Ack

   // Master signals hold until the slave answers
   assert property (@(posedge clk) disable iff (!rstN)
      wbStb && !wbAck |=> wbStb && $stable({wbWe, wbAdr, wbDatO}));

   assert property (@(posedge clk) disable iff (!rstN) wbCyc == wbStb);

endmodule

//--- executeStage.sv
`timescale 1ns/1ps
/* ALU and branch resolution. Targets are word addresses, PC + 1 + offset.
   A taken branch redirects once, in the cycle it moves on to memory */
module executeStage (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic                       memBusy,
   input  logic                       deValid,
   input  procPkg::opcodeT            deOp,
   input  procPkg::aluOpT             deAluOp,
   input  logic [procPkg::DATA_W-1:0] deA,
   input  logic [procPkg::DATA_W-1:0] deB,
   input  logic [procPkg::DATA_W-1:0] deImm,
   input  logic                       deUseImm,
   input  logic [procPkg::DATA_W-1:0] dePc,
   input  logic [procPkg::REG_AW-1:0] deDest,
   input  logic                       deWrite,
   output logic                       redirect,
   output logic [procPkg::DATA_W-1:0] redirectPc,
   output logic                       emValid,
   output logic [procPkg::DATA_W-1:0] emResult,
   output logic [procPkg::DATA_W-1:0] emStoreData,
   output logic                       emLoad,
   output logic                       emStore,
   output logic [procPkg::REG_AW-1:0] emDest,
   output logic                       emWrite,
   output logic                       emHalt
);

   logic [procPkg::DATA_W-1:0] bOp;
   logic [procPkg::DATA_W-1:0] aluOut;
   logic                       taken;

   assign bOp = deUseImm ? deImm : deB;

   always_comb begin
      case (deAluOp)
         procPkg::ALU_SUB:   aluOut = deA - bOp;
         procPkg::ALU_AND:   aluOut = deA & bOp;
         procPkg::ALU_XOR:   aluOut = deA ^ bOp;
         procPkg::ALU_PASSB: aluOut = bOp;
         default:            aluOut = deA + bOp;  // Also load and store address
      endcase
   end

   always_comb begin
      case (deOp)
         procPkg::OP_BEQZ: taken = (deA == '0);
         procPkg::OP_BNEZ: taken = (deA != '0);
         procPkg::OP_J:    taken = 1'b1;
         default:          taken = 1'b0;
      endcase
   end

   assign redirect   = deValid && taken && !memBusy;
   assign redirectPc = dePc + 1 + deImm;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
         emValid <= 1'b0;
      else if (!memBusy)
         emValid <= deValid;
   end

   always_ff @(posedge clk) begin
      if (!memBusy) begin
         emResult    <= aluOut;
         emStoreData <= deB;
         emLoad      <= (deOp == procPkg::OP_LD);
         emStore     <= (deOp == procPkg::OP_ST);
         emDest      <= deDest;
         emWrite     <= deWrite;
         emHalt      <= (deOp == procPkg::OP_HALT);
      end
   end

   // A redirecting branch is real and moves on to memory next cycle
   assert property (@(posedge clk) disable iff (!rstN)
      redirect |-> deValid ##1 emValid);

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps
/* Decode, register file and interlock. No forwarding: a dependent op waits
   until its producer writes back. Unknown opcodes pass on as NOPs and set err */
module decodeStage (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [procPkg::DATA_W-1:0] fdInstr,
   input  logic [procPkg::DATA_W-1:0] fdPc,
   input  logic                       fdValid,
   input  logic                       flush,
   input  logic                       memBusy,
   input  logic [procPkg::REG_AW-1:0] exDest,
   input  logic                       exWrite,
   input  logic                       exValid,
   input  logic [procPkg::REG_AW-1:0] memDest,
   input  logic                       memWrite,
   input  logic                       memValid,
   input  logic                       wbRegWe,
   input  logic [procPkg::REG_AW-1:0] wbRegAddr,
   input  logic [procPkg::DATA_W-1:0] wbRegData,
   output logic                       hazard,
   output logic                       err,
   output logic                       deValid,
   output procPkg::opcodeT            deOp,
   output procPkg::aluOpT             deAluOp,
   output logic [procPkg::DATA_W-1:0] deA,
   output logic [procPkg::DATA_W-1:0] deB,
   output logic [procPkg::DATA_W-1:0] deImm,
   output logic                       deUseImm,
   output logic [procPkg::DATA_W-1:0] dePc,
   output logic [procPkg::REG_AW-1:0] deDest,
   output logic                       deWrite
);

   logic [procPkg::DATA_W-1:0] regFile [2**procPkg::REG_AW];
   procPkg::opcodeT            op;
   procPkg::aluOpT             aluOp;
   logic [procPkg::REG_AW-1:0] rs, rt, rd, dest;
   logic [procPkg::DATA_W-1:0] imm5Ext, imm8Ext, dispExt, imm;
   logic [procPkg::DATA_W-1:0] rsVal, rtVal;
   logic                       useRs, useRt, useImm, write, legal;
   logic                       rsHit, rtHit;

   assign op = procPkg::opcodeT'(fdInstr[procPkg::DATA_W-1 -: procPkg::OPC_W]);
   assign rs = fdInstr[procPkg::RS_MSB -: procPkg::REG_AW];
   assign rt = fdInstr[procPkg::RT_MSB -: procPkg::REG_AW];
   assign rd = fdInstr[procPkg::RD_MSB -: procPkg::REG_AW];

   assign imm5Ext = {{(procPkg::DATA_W-procPkg::IMM5_W){fdInstr[procPkg::IMM5_W-1]}},
                     fdInstr[procPkg::IMM5_W-1:0]};
   assign imm8Ext = {{(procPkg::DATA_W-procPkg::IMM8_W){fdInstr[procPkg::IMM8_W-1]}},
                     fdInstr[procPkg::IMM8_W-1:0]};
   assign dispExt = {{(procPkg::DATA_W-procPkg::DISP_W){fdInstr[procPkg::DISP_W-1]}},
                     fdInstr[procPkg::DISP_W-1:0]};

   always_comb begin
      imm    = imm5Ext;                   // ADDI, LD and ST offset
      dest   = rt;                        // Immediate ops and loads
      useRs  = 1'b0;
      useRt  = 1'b0;
      useImm = 1'b0;
      write  = 1'b0;
      legal  = 1'b1;
      case (op)
         procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND, procPkg::OP_XOR: begin
            useRs = 1'b1;
            useRt = 1'b1;
            write = 1'b1;
            dest  = rd;
         end
         procPkg::OP_ADDI, procPkg::OP_LD: begin
            useRs  = 1'b1;
            useImm = 1'b1;
            write  = 1'b1;
         end
         procPkg::OP_ST: begin
            useRs  = 1'b1;
            useRt  = 1'b1;                // Store data comes from 7:5
            useImm = 1'b1;
         end
         procPkg::OP_LBI: begin
            imm    = imm8Ext;
            useImm = 1'b1;
            write  = 1'b1;
            dest   = rs;                  // 7:0 holds the value itself
         end
         procPkg::OP_BEQZ, procPkg::OP_BNEZ: begin
            imm   = imm8Ext;
            useRs = 1'b1;
         end
         procPkg::OP_J:    imm = dispExt;
         procPkg::OP_HALT: ;
         default:          legal = 1'b0;
      endcase
   end

   always_comb begin
      case (op)
         procPkg::OP_SUB: aluOp = procPkg::ALU_SUB;
         procPkg::OP_AND: aluOp = procPkg::ALU_AND;
         procPkg::OP_XOR: aluOp = procPkg::ALU_XOR;
         procPkg::OP_LBI: aluOp = procPkg::ALU_PASSB;
         default:         aluOp = procPkg::ALU_ADD;  // Addresses and ADD
      endcase
   end

   // Write-through so a register written this cycle reads new
   assign rsVal = (wbRegWe && wbRegAddr == rs) ? wbRegData : regFile[rs];
   assign rtVal = (wbRegWe && wbRegAddr == rt) ? wbRegData : regFile[rt];

   // Memory-stage producer stops blocking in the cycle it writes
   assign rsHit = useRs && ((exValid && exWrite && exDest == rs) ||
                            (memValid && memWrite && !wbRegWe && memDest == rs));
   assign rtHit = useRt && ((exValid && exWrite && exDest == rt) ||
                            (memValid && memWrite && !wbRegWe && memDest == rt));
   assign hazard = fdValid && (rsHit || rtHit);

   always_ff @(posedge clk) begin
      if (wbRegWe)
         regFile[wbRegAddr] <= wbRegData;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         deValid <= 1'b0;
         err     <= 1'b0;
      end else if (!memBusy) begin
         deValid <= fdValid && !flush && !hazard;  // Bubble on flush or hazard
         if (fdValid && !flush && !legal)
            err <= 1'b1;                  // Sticky until reset
      end
   end

   always_ff @(posedge clk) begin
      if (!memBusy && !hazard) begin
         deOp     <= op;
         deAluOp  <= aluOp;
         deA      <= rsVal;
         deB      <= rtVal;
         deImm    <= imm;
         deUseImm <= useImm;
         dePc     <= fdPc;
         deDest   <= dest;
         deWrite  <= write;
      end
   end

   // An unknown opcode can enter execute only with err already raised
   assert property (@(posedge clk) disable iff (!rstN)
      deValid && !err |-> deOp inside {procPkg::OP_HALT, procPkg::OP_J, procPkg::OP_ADDI,
         procPkg::OP_BEQZ, procPkg::OP_BNEZ, procPkg::OP_ST, procPkg::OP_LD, procPkg::OP_LBI,
         procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND, procPkg::OP_XOR});

endmodule

//--- fetchStage.sv
`timescale 1ns/1ps
/* Fetch for a one-cycle synchronous-read instruction port.
   A word dropped by a stall is requested again, not buffered */
module fetchStage (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic                       stall,
   input  logic                       redirect,
   input  logic                       halt,
   input  logic [procPkg::DATA_W-1:0] redirectPc,
   input  logic [procPkg::DATA_W-1:0] iData,
   output logic [procPkg::DATA_W-1:0] iAddr,
   output logic                       iReq,
   output logic [procPkg::DATA_W-1:0] fdInstr,
   output logic [procPkg::DATA_W-1:0] fdPc,
   output logic                       fdValid
);

   logic [procPkg::DATA_W-1:0] pc;        // Next sequential address
   logic [procPkg::DATA_W-1:0] reqPc;     // Address of the word now on iData
   logic                       reqValid;  // Word on iData is on the current path

   assign iReq = !halt;                   // Fetch stops for good after HALT

   always_comb begin
      if (redirect)
         iAddr = redirectPc;              // Target goes out in the resolve cycle
      else if (stall)
         iAddr = reqPc;                   // Replay the word that is dropped now
      else
         iAddr = pc;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc       <= '0;                  // Start at address 0
         reqPc    <= '0;
         reqValid <= 1'b0;
         fdValid  <= 1'b0;
      end else if (halt) begin
         reqValid <= 1'b0;
         fdValid  <= 1'b0;
      end else begin
         reqPc <= iAddr;
         if (redirect) begin
            pc       <= redirectPc + 1;
            reqValid <= 1'b1;
            fdValid  <= 1'b0;             // Squash the word arriving now
         end else if (!stall) begin
            pc       <= pc + 1;
            reqValid <= 1'b1;
            fdValid  <= reqValid;
         end
      end
   end

   // Held word stays put while decode or memory cannot accept
   always_ff @(posedge clk) begin
      if (!stall && !redirect) begin
         fdInstr <= iData;
         fdPc    <= reqPc;
      end
   end

endmodule

//--- procPkg.sv
/* Shared widths, field positions and encodings of the 16-bit core.
   Opcode values cover only the supported subset. Any other code raises err */
package procPkg;

   localparam int DATA_W = 16;   // Data, word address and instruction width
   localparam int REG_AW = 3;    // Eight registers
   localparam int OPC_W  = 5;    // Opcode sits in the top bits
   localparam int RS_MSB = 10;   // First register field 10:8
   localparam int RT_MSB = 7;    // Second register field 7:5
   localparam int RD_MSB = 4;    // Third register field 4:2
   localparam int IMM5_W = 5;    // ADDI, LD, ST offset
   localparam int IMM8_W = 8;    // LBI value and branch offset
   localparam int DISP_W = 11;   // J displacement

   typedef enum logic [OPC_W-1:0] {
      OP_HALT = 5'b00000,        // Stops fetch once it reaches memory
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,        // Stores the second register field
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,        // Writes the first register field
      OP_ADD  = 5'b11011,
      OP_SUB  = 5'b11100,        // Rs minus Rt
      OP_AND  = 5'b11101,
      OP_XOR  = 5'b11110
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_XOR   = 3'd3,
      ALU_PASSB = 3'd4           // Result is operand B, used by LBI
   } aluOpT;

endpackage
